/* hw/axi_pkg.sv */
package axi_pkg;

  // Bus widths, shared by both sides of the bridge
  localparam int ADDR_W = 16;
  localparam int DATA_W = 32;
  localparam int ID_W   = 4;

  typedef logic [ADDR_W-1:0] axi_addr_t;
  typedef logic [DATA_W-1:0] axi_data_t;
  typedef logic [ID_W-1:0]   axi_id_t;

  // Beats minus one
  typedef logic [7:0] axi_len_t;
  // Log2 of bytes per beat
  typedef logic [2:0] axi_size_t;
  typedef logic [1:0] axi_burst_t;
  typedef logic [1:0] axi_resp_t;

  // Burst type codes, code 3 is reserved
  localparam axi_burst_t BURST_FIXED = 2'b00;
  localparam axi_burst_t BURST_INCR  = 2'b01;
  localparam axi_burst_t BURST_WRAP  = 2'b10;

  localparam axi_resp_t RESP_OKAY   = 2'b00;
  localparam axi_resp_t RESP_SLVERR = 2'b10;

endpackage

/* hw/bridge_pkg.sv */
package bridge_pkg;

  // Max AXI-Lite reads in flight
  localparam int TAG_DEPTH = 4;
  localparam int TAG_PTR_W = 2;
  // Occupancy needs one more bit than the pointers
  localparam int TAG_CNT_W = TAG_PTR_W + 1;

  // Beat tag packed as {id, last}
  typedef logic [$bits(axi_pkg::axi_id_t):0] beat_tag_t;

  // Burst iterator FSM
  typedef enum logic {
    ITER_IDLE,
    ITER_ISSUE
  } iter_state_t;

endpackage

/* hw/ar_beat_if.sv */
`timescale 1ns/1ps

// One split read beat, iterator to reflector
interface ar_beat_if;
  import axi_pkg::*;

  logic      valid;
  axi_addr_t addr;
  axi_id_t   id;
  logic      last;
  logic      ready;

  modport src (
    output valid, addr, id, last,
    input  ready
  );

  modport dst (
    input  valid, addr, id, last,
    output ready
  );

endinterface

/* hw/axi_burst_iter_ar.sv */
`timescale 1ns/1ps

module axi_burst_iter_ar (
  input  logic                 clk,
  input  logic                 i_rst_n,

  input  logic                 i_arvalid,
  input  axi_pkg::axi_id_t     i_arid,
  input  axi_pkg::axi_addr_t   i_araddr,
  input  axi_pkg::axi_len_t    i_arlen,
  input  axi_pkg::axi_size_t   i_arsize,
  input  axi_pkg::axi_burst_t  i_arburst,
  output logic                 o_arready,

  ar_beat_if.src               beat
);
  import axi_pkg::*;
  import bridge_pkg::*;

  iter_state_t state_q;

  // Held burst
  axi_addr_t   addr_q;
  axi_addr_t   wrap_mask_q;
  axi_id_t     id_q;
  axi_len_t    remain_q;
  axi_size_t   size_q;
  axi_burst_t  burst_q;

  axi_addr_t   step;
  axi_addr_t   incr_addr;
  axi_addr_t   next_addr;

  logic        ar_fire;
  logic        beat_fire;
  logic        last_beat;

  // Only accept a new burst once the previous one is fully issued
  assign o_arready = (state_q == ITER_IDLE);
  assign ar_fire   = i_arvalid && o_arready;
  assign beat_fire = beat.valid && beat.ready;
  assign last_beat = (remain_q == '0);

  assign beat.valid = (state_q == ITER_ISSUE);
  assign beat.addr  = addr_q;
  assign beat.id    = id_q;
  assign beat.last  = last_beat;

  // Next beat address
  always_comb begin
    step      = axi_addr_t'(1) << size_q;
    incr_addr = addr_q + step;
    case (burst_q)
      BURST_FIXED: begin
        next_addr = addr_q;
      end
      BURST_WRAP: begin
        // Upper bits stay on the window base, low bits roll over
        next_addr = (addr_q & ~wrap_mask_q) | (incr_addr & wrap_mask_q);
      end
      default: begin
        // INCR, and reserved code 3 handled the same way
        next_addr = incr_addr;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      state_q  <= ITER_IDLE;
      remain_q <= '0;
    end else begin
      case (state_q)
        ITER_IDLE: begin
          if (ar_fire) begin
            state_q  <= ITER_ISSUE;
            remain_q <= i_arlen;
          end
        end
        ITER_ISSUE: begin
          if (beat_fire) begin
            if (last_beat) begin
              state_q <= ITER_IDLE;
            end else begin
              remain_q <= remain_q - 1'b1;
            end
          end
        end
        default: begin
          state_q <= ITER_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (ar_fire) begin
      addr_q      <= i_araddr;
      id_q        <= i_arid;
      size_q      <= i_arsize;
      burst_q     <= i_arburst;
      // Window of beats times beat size, minus one
      wrap_mask_q <= ((axi_addr_t'(i_arlen) + axi_addr_t'(1)) << i_arsize) - axi_addr_t'(1);
    end else if (beat_fire && !last_beat) begin
      addr_q <= next_addr;
    end
  end

endmodule

/* hw/rd_tag_fifo.sv */
`timescale 1ns/1ps

module rd_tag_fifo (
  input  logic                   clk,
  input  logic                   i_rst_n,

  input  logic                   i_push,
  input  bridge_pkg::beat_tag_t  i_push_tag,
  input  logic                   i_pop,

  output bridge_pkg::beat_tag_t  o_head_tag,
  output logic                   o_full,
  output logic                   o_empty
);
  import bridge_pkg::*;

  beat_tag_t              mem [TAG_DEPTH];
  logic [TAG_PTR_W-1:0]   wr_ptr_q;
  logic [TAG_PTR_W-1:0]   rd_ptr_q;
  logic [TAG_CNT_W-1:0]   count_q;

  logic                   do_push;
  logic                   do_pop;

  assign o_full  = (count_q == TAG_CNT_W'(TAG_DEPTH));
  assign o_empty = (count_q == '0);

  assign do_push = i_push && !o_full;
  assign do_pop  = i_pop && !o_empty;

  assign o_head_tag = mem[rd_ptr_q];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr_q] <= i_push_tag;
    end
  end

  // Pointers wrap by overflow, depth is a power of two
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // Push and pop together leave the count as is
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

/* hw/axil_rd_reflect.sv */
`timescale 1ns/1ps

module axil_rd_reflect (
  input  logic                clk,
  input  logic                i_rst_n,

  ar_beat_if.dst              beat,

  // AXI-Lite manager side
  output logic                o_m_axil_arvalid,
  output axi_pkg::axi_addr_t  o_m_axil_araddr,
  input  logic                i_m_axil_arready,
  input  logic                i_m_axil_rvalid,
  input  axi_pkg::axi_data_t  i_m_axil_rdata,
  input  axi_pkg::axi_resp_t  i_m_axil_rresp,
  output logic                o_m_axil_rready,

  // AXI read data back to the burst master
  output logic                o_s_axi_rvalid,
  output axi_pkg::axi_id_t    o_s_axi_rid,
  output axi_pkg::axi_data_t  o_s_axi_rdata,
  output axi_pkg::axi_resp_t  o_s_axi_rresp,
  output logic                o_s_axi_rlast,
  input  logic                i_s_axi_rready
);
  import axi_pkg::*;
  import bridge_pkg::*;

  beat_tag_t  push_tag;
  beat_tag_t  head_tag;
  logic       fifo_full;
  logic       fifo_empty;
  logic       ar_fire;
  logic       r_fire;

  // AR side, a beat goes out only if its tag has a slot
  assign o_m_axil_arvalid = beat.valid && !fifo_full;
  assign o_m_axil_araddr  = beat.addr;
  assign beat.ready       = i_m_axil_arready && !fifo_full;

  assign ar_fire  = o_m_axil_arvalid && i_m_axil_arready;
  assign push_tag = {beat.id, beat.last};

  // R side is a straight pass with ID and last from the oldest tag
  assign o_s_axi_rvalid  = i_m_axil_rvalid;
  assign o_m_axil_rready = i_s_axi_rready;
  assign o_s_axi_rdata   = i_m_axil_rdata;
  assign o_s_axi_rresp   = i_m_axil_rresp;

  assign {o_s_axi_rid, o_s_axi_rlast} = head_tag;

  // Responses return in order, so the head always matches
  assign r_fire = i_m_axil_rvalid && i_s_axi_rready && !fifo_empty;

  rd_tag_fifo tag_fifo (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_push     (ar_fire),
    .i_push_tag (push_tag),
    .i_pop      (r_fire),
    .o_head_tag (head_tag),
    .o_full     (fifo_full),
    .o_empty    (fifo_empty)
  );

endmodule

/* hw/axi_axil_rd.sv */
`timescale 1ns/1ps

// Read-only AXI4 to AXI-Lite bridge, same data width on both sides
module axi_axil_rd (
  input  logic                 clk,
  input  logic                 i_rst_n,

  // AXI subordinate read address
  input  logic                 i_s_axi_arvalid,
  input  axi_pkg::axi_id_t     i_s_axi_arid,
  input  axi_pkg::axi_addr_t   i_s_axi_araddr,
  input  axi_pkg::axi_len_t    i_s_axi_arlen,
  input  axi_pkg::axi_size_t   i_s_axi_arsize,
  input  axi_pkg::axi_burst_t  i_s_axi_arburst,
  output logic                 o_s_axi_arready,

  // AXI subordinate read data
  output logic                 o_s_axi_rvalid,
  output axi_pkg::axi_id_t     o_s_axi_rid,
  output axi_pkg::axi_data_t   o_s_axi_rdata,
  output axi_pkg::axi_resp_t   o_s_axi_rresp,
  output logic                 o_s_axi_rlast,
  input  logic                 i_s_axi_rready,

  // AXI-Lite manager
  output logic                 o_m_axil_arvalid,
  output axi_pkg::axi_addr_t   o_m_axil_araddr,
  input  logic                 i_m_axil_arready,
  input  logic                 i_m_axil_rvalid,
  input  axi_pkg::axi_data_t   i_m_axil_rdata,
  input  axi_pkg::axi_resp_t   i_m_axil_rresp,
  output logic                 o_m_axil_rready
);

  ar_beat_if beat ();

  axi_burst_iter_ar burst_iter (
    .clk       (clk),
    .i_rst_n   (i_rst_n),
    .i_arvalid (i_s_axi_arvalid),
    .i_arid    (i_s_axi_arid),
    .i_araddr  (i_s_axi_araddr),
    .i_arlen   (i_s_axi_arlen),
    .i_arsize  (i_s_axi_arsize),
    .i_arburst (i_s_axi_arburst),
    .o_arready (o_s_axi_arready),
    .beat      (beat.src)
  );

  axil_rd_reflect rd_reflect (
    .clk              (clk),
    .i_rst_n          (i_rst_n),
    .beat             (beat.dst),
    .o_m_axil_arvalid (o_m_axil_arvalid),
    .o_m_axil_araddr  (o_m_axil_araddr),
    .i_m_axil_arready (i_m_axil_arready),
    .i_m_axil_rvalid  (i_m_axil_rvalid),
    .i_m_axil_rdata   (i_m_axil_rdata),
    .i_m_axil_rresp   (i_m_axil_rresp),
    .o_m_axil_rready  (o_m_axil_rready),
    .o_s_axi_rvalid   (o_s_axi_rvalid),
    .o_s_axi_rid      (o_s_axi_rid),
    .o_s_axi_rdata    (o_s_axi_rdata),
    .o_s_axi_rresp    (o_s_axi_rresp),
    .o_s_axi_rlast    (o_s_axi_rlast),
    .i_s_axi_rready   (i_s_axi_rready)
  );

endmodule

/* sim/axil_mem_model.sv */
`timescale 1ns/1ps

// AXI-Lite read target, answers in request order with random stalls
module axil_mem_model #(
  parameter logic [31:0]        SEED      = 32'd27,
  parameter int                 STALL_PCT = 30,
  parameter axi_pkg::axi_addr_t ERR_BASE  = 16'hF000
) (
  input  logic                clk,
  input  logic                i_rst_n,

  input  logic                i_arvalid,
  input  axi_pkg::axi_addr_t  i_araddr,
  output logic                o_arready,

  output logic                o_rvalid,
  output axi_pkg::axi_data_t  o_rdata,
  output axi_pkg::axi_resp_t  o_rresp,
  input  logic                i_rready
);
  import axi_pkg::*;

  // Accepted addresses still waiting for a response
  axi_addr_t    pend_q[$];
  axi_addr_t    rd_addr;
  logic [31:0]  rng_q;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] v;
    v = x;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  initial begin
    o_arready = 1'b0;
    o_rvalid  = 1'b0;
    o_rdata   = '0;
    o_rresp   = RESP_OKAY;
    rng_q     = SEED;
  end

  always @(posedge clk) begin
    if (!i_rst_n) begin
      rng_q = SEED;
      pend_q.delete();
      o_arready <= 1'b0;
      o_rvalid  <= 1'b0;
      o_rdata   <= '0;
      o_rresp   <= RESP_OKAY;
    end else begin
      rng_q = xorshift32(rng_q);
      if (i_arvalid && o_arready) begin
        pend_q.push_back(i_araddr);
      end
      if (o_rvalid && i_rready) begin
        o_rvalid <= 1'b0;
      end
      // Next response only once the current one has been taken
      if ((!o_rvalid || i_rready) && pend_q.size() != 0 && (rng_q[15:8] % 100) >= STALL_PCT) begin
        rd_addr = pend_q.pop_front();
        o_rvalid <= 1'b1;
        o_rdata  <= {rd_addr, rd_addr} ^ 32'hA5A5_0000;
        o_rresp  <= (rd_addr >= ERR_BASE) ? RESP_SLVERR : RESP_OKAY;
      end
      o_arready <= ((rng_q[7:0] % 100) >= STALL_PCT);
    end
  end

endmodule

/* sim/axi_axil_rd_tb.sv */
`timescale 1ns/1ps

module axi_axil_rd_tb;
  import axi_pkg::*;

  localparam logic [31:0] SEED       = 32'd27;
  localparam int          STALL_PCT  = 30;
  localparam axi_addr_t   ERR_BASE   = 16'hF000;
  localparam int          DRIVE_DLY  = 1;
  // About 70 beats, each well under 100 cycles even with long rready gaps
  localparam int          TIMEOUT_CYCLES = 20000;

  logic       clk;
  logic       i_rst_n;
  logic       i_s_axi_arvalid;
  axi_id_t    i_s_axi_arid;
  axi_addr_t  i_s_axi_araddr;
  axi_len_t   i_s_axi_arlen;
  axi_size_t  i_s_axi_arsize;
  axi_burst_t i_s_axi_arburst;
  logic       o_s_axi_arready;
  logic       o_s_axi_rvalid;
  axi_id_t    o_s_axi_rid;
  axi_data_t  o_s_axi_rdata;
  axi_resp_t  o_s_axi_rresp;
  logic       o_s_axi_rlast;
  logic       i_s_axi_rready;
  logic       o_m_axil_arvalid;
  axi_addr_t  o_m_axil_araddr;
  logic       i_m_axil_arready;
  logic       i_m_axil_rvalid;
  axi_data_t  i_m_axil_rdata;
  axi_resp_t  i_m_axil_rresp;
  logic       o_m_axil_rready;

  // Expected AXI-Lite addresses and R beats, in issue order
  axi_addr_t  exp_addr_q[$];
  axi_data_t  exp_data_q[$];
  axi_resp_t  exp_resp_q[$];
  axi_id_t    exp_id_q[$];
  logic       exp_last_q[$];

  logic        rready_random;
  logic [31:0] rready_rng;
  logic [31:0] stim_rng;
  int          hold_cnt;
  int          cycle_cnt;

  axi_axil_rd dut0 (.*);

  axil_mem_model #(
    .SEED      (SEED),
    .STALL_PCT (STALL_PCT),
    .ERR_BASE  (ERR_BASE)
  ) mem0 (
    .clk       (clk),
    .i_rst_n   (i_rst_n),
    .i_arvalid (o_m_axil_arvalid),
    .i_araddr  (o_m_axil_araddr),
    .o_arready (i_m_axil_arready),
    .o_rvalid  (i_m_axil_rvalid),
    .o_rdata   (i_m_axil_rdata),
    .o_rresp   (i_m_axil_rresp),
    .i_rready  (o_m_axil_rready)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] v;
    v = x;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  // Address of beat n by the AXI burst rules
  function automatic axi_addr_t beat_addr(input axi_addr_t start, input axi_len_t len,
                                          input axi_size_t size, input axi_burst_t burst,
                                          input int n);
    int unsigned bytes;
    int unsigned span;
    int unsigned base;
    bytes = 1 << size;
    span  = (int'(len) + 1) * bytes;
    base  = start - (start % span);
    case (burst)
      BURST_FIXED: return start;
      BURST_WRAP:  return axi_addr_t'(base + ((start - base + n * bytes) % span));
      default:     return axi_addr_t'(start + n * bytes);
    endcase
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_data(input axi_data_t got, input axi_data_t exp);
    if (got !== exp) begin
      report_failure($sformatf("error o_s_axi_rdata got %h expected %h", got, exp));
    end
  endtask

  task automatic check_resp(input axi_resp_t got, input axi_resp_t exp);
    if (got !== exp) begin
      report_failure($sformatf("error o_s_axi_rresp got %h expected %h", got, exp));
    end
  endtask

  task automatic check_id(input axi_id_t got, input axi_id_t exp);
    if (got !== exp) begin
      report_failure($sformatf("error o_s_axi_rid got %h expected %h", got, exp));
    end
  endtask

  task automatic check_last(input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("error o_s_axi_rlast got %h expected %h", got, exp));
    end
  endtask

  task automatic check_addr(input axi_addr_t got, input axi_addr_t exp);
    if (got !== exp) begin
      report_failure($sformatf("error o_m_axil_araddr got %h expected %h", got, exp));
    end
  endtask

  // Handshake and control bits
  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("error %s got %h expected %h", name, got, exp));
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      report_failure("timeout: the bridge stopped returning read beats");
    end
  end

  // All handshakes are sampled mid-cycle where every signal is settled
  always @(negedge clk) begin
    if (i_rst_n) begin
      // AXI-Lite rready follows AXI rready
      check_flag("o_m_axil_rready", o_m_axil_rready, i_s_axi_rready);
    end
    if (i_rst_n && o_m_axil_arvalid && i_m_axil_arready) begin
      if (exp_addr_q.size() == 0) begin
        report_failure("AXI-Lite read issued with no beat outstanding");
      end
      check_addr(o_m_axil_araddr, exp_addr_q.pop_front());
    end
    if (i_rst_n && o_s_axi_rvalid && i_s_axi_rready) begin
      if (exp_id_q.size() == 0) begin
        report_failure("AXI R beat returned with no beat outstanding");
      end
      check_data(o_s_axi_rdata, exp_data_q.pop_front());
      check_resp(o_s_axi_rresp, exp_resp_q.pop_front());
      check_id(o_s_axi_rid, exp_id_q.pop_front());
      check_last(o_s_axi_rlast, exp_last_q.pop_front());
    end
  end

  // rready high, or in random stretches high and low
  always @(posedge clk) begin
    #DRIVE_DLY;
    if (!rready_random) begin
      i_s_axi_rready = 1'b1;
      hold_cnt = 0;
    end else if (hold_cnt == 0) begin
      rready_rng = xorshift32(rready_rng);
      i_s_axi_rready = (rready_rng[1:0] != 2'b00);
      hold_cnt = rready_rng[5:2];
    end else begin
      hold_cnt = hold_cnt - 1;
    end
  end

  task automatic send_burst(input axi_id_t id, input axi_addr_t start, input axi_len_t len,
                            input axi_size_t size, input axi_burst_t burst);
    axi_addr_t a;
    for (int n = 0; n <= int'(len); n++) begin
      a = beat_addr(start, len, size, burst, n);
      exp_addr_q.push_back(a);
      exp_data_q.push_back({a ^ 16'hA5A5, a});
      exp_resp_q.push_back((a >= ERR_BASE) ? RESP_SLVERR : RESP_OKAY);
      exp_id_q.push_back(id);
      exp_last_q.push_back(n == int'(len));
    end
    i_s_axi_arvalid = 1'b1;
    i_s_axi_arid    = id;
    i_s_axi_araddr  = start;
    i_s_axi_arlen   = len;
    i_s_axi_arsize  = size;
    i_s_axi_arburst = burst;
    do begin
      @(negedge clk);
    end while (!o_s_axi_arready);
    @(posedge clk);
    #DRIVE_DLY;
    i_s_axi_arvalid = 1'b0;
  endtask

  task automatic wait_drained();
    while (exp_id_q.size() != 0 || exp_addr_q.size() != 0) begin
      @(negedge clk);
    end
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  // Idle outputs while reset is held
  task automatic test_reset_state();
    check_flag("o_s_axi_arready", o_s_axi_arready, 1'b1);
    check_flag("o_m_axil_arvalid", o_m_axil_arvalid, 1'b0);
    check_flag("o_s_axi_rvalid", o_s_axi_rvalid, 1'b0);
  endtask

  task automatic test_single();
    send_burst(4'h1, 16'h0100, 8'd0, 3'd2, BURST_INCR);
    wait_drained();
  endtask

  task automatic test_incr();
    send_burst(4'h2, 16'h0200, 8'd7, 3'd2, BURST_INCR);
    wait_drained();
  endtask

  task automatic test_wrap();
    // 16-byte window at 0x300, start in its middle
    send_burst(4'h3, 16'h0308, 8'd3, 3'd2, BURST_WRAP);
    wait_drained();
  endtask

  task automatic test_fixed();
    send_burst(4'h4, 16'h0400, 8'd3, 3'd2, BURST_FIXED);
    wait_drained();
  endtask

  task automatic test_stress();
    axi_burst_t burst;
    axi_len_t   len;
    axi_size_t  size;
    axi_addr_t  start;
    rready_random = 1'b1;
    for (int i = 0; i < 8; i++) begin
      stim_rng = xorshift32(stim_rng);
      burst = axi_burst_t'(stim_rng[1:0] % 3);
      size  = axi_size_t'(stim_rng[3:2] % 3);
      if (burst == BURST_WRAP) begin
        len = axi_len_t'((2 << (stim_rng[5:4] % 3)) - 1);
      end else begin
        len = axi_len_t'(stim_rng[7:4]);
      end
      start = axi_addr_t'(16'h1000 + i * 16'h0100 + (stim_rng[11:8] << size));
      send_burst(axi_id_t'(i + 5), start, len, size, burst);
    end
    wait_drained();
    rready_random = 1'b0;
  endtask

  task automatic test_error();
    // Two beats below the error region, two inside it
    send_burst(4'hB, 16'hEFF8, 8'd3, 3'd2, BURST_INCR);
    wait_drained();
  endtask

  initial begin
    i_rst_n         = 1'b0;
    i_s_axi_arvalid = 1'b0;
    i_s_axi_arid    = '0;
    i_s_axi_araddr  = '0;
    i_s_axi_arlen   = '0;
    i_s_axi_arsize  = '0;
    i_s_axi_arburst = BURST_INCR;
    i_s_axi_rready  = 1'b1;
    rready_random   = 1'b0;
    rready_rng      = SEED;
    stim_rng        = SEED;
    hold_cnt        = 0;
    cycle_cnt       = 0;
    repeat (16) @(posedge clk);
    #DRIVE_DLY;
    test_reset_state();
    i_rst_n = 1'b1;
    @(posedge clk);
    #DRIVE_DLY;
    test_single();
    test_incr();
    test_wrap();
    test_fixed();
    test_stress();
    test_error();
    repeat (20) @(posedge clk);
    if (exp_id_q.size() != 0 || exp_addr_q.size() != 0) begin
      report_failure("read beats still outstanding at the end of the run");
    end else begin
      $display("STATUS: PASS");
      $finish;
    end
  end

endmodule

/* build.f */
hw/axi_pkg.sv
hw/bridge_pkg.sv
hw/ar_beat_if.sv
hw/axi_burst_iter_ar.sv
hw/rd_tag_fifo.sv
hw/axil_rd_reflect.sv
hw/axi_axil_rd.sv
sim/axil_mem_model.sv
sim/axi_axil_rd_tb.sv
